/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_leaf_i2o3 \
    --Mdir obj_dir \
    -o sim_leaf_i2o3

./obj_dir/sim_leaf_i2o3 > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

/* sim.f */
verilog/leaf_pkg.sv
verilog/stream_fifo.sv
verilog/leaf_unpacker.sv
verilog/leaf_packer.sv
verilog/leaf_interface.sv
verilog/pair_kernel.sv
verilog/leaf_i2o3.sv
test/tb_leaf_i2o3.sv

/* test/leaf_tests.txt */
# Records: test name | cfg out leaf port | start | quiet cycles | resend offset length
# pair in1 in2 | expect leaf port source payload   (all numbers in hex)
test no_start
pair 00000011 00000022
quiet 20
start
pair 00000005 00000003
expect 00 0 1 00000008
expect 00 0 2 00000006
expect 00 0 3 00000002
test routes
cfg 1 03 1
cfg 2 05 2
cfg 3 0a 3
pair 12345678 11111111
expect 03 1 1 23456789
expect 05 2 2 03254769
expect 0a 3 3 01234567
test in_order
pair 00000010 00000001
pair 00000020 00000003
pair a5a5a5a5 5a5a5a5a
expect 03 1 1 00000011
expect 03 1 1 00000023
expect 03 1 1 ffffffff
expect 05 2 2 00000011
expect 05 2 2 00000023
expect 05 2 2 ffffffff
expect 0a 3 3 0000000f
expect 0a 3 3 0000001d
expect 0a 3 3 4b4b4b4b
test resend
pair 00000007 00000009
resend 2 0c
pair deadbeef 00000001
expect 03 1 1 00000010
expect 03 1 1 deadbef0
expect 05 2 2 0000000e
expect 05 2 2 deadbeee
expect 0a 3 3 fffffffe
expect 0a 3 3 deadbeee
test reconfig
cfg 2 11 6
pair 00000064 0000000a
expect 03 1 1 0000006e
expect 11 6 2 0000006e
expect 0a 3 3 0000005a

/* test/tb_leaf_i2o3.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_leaf_i2o3;
    import leaf_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int SETTLE_CYCLES  = 20;

    logic    clk;
    logic    rst_n;
    logic    resend;
    logic    ap_start;
    packet_t din;
    packet_t dout;

    packet_t got_q [NUM_OUT_PORTS][$];  // Captured packets per source output
    packet_t exp_q [NUM_OUT_PORTS][$];
    int      cycle;
    int      rs_start;
    int      rs_len;
    int      mon_src;
    int      check_count;
    int      error_count;
    int      test_count;
    int      test_checks;
    int      test_errors;
    string   test_name;
    logic    test_open;

    leaf_i2o3 i_leaf_i2o3 (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Resend window against a free-running cycle count
    initial begin
        cycle    = 0;
        rs_start = 0;
        rs_len   = 0;
        resend   = 1'b0;
        forever begin
            @(posedge clk);
            cycle = cycle + 1;
            #2;
            resend = (cycle >= rs_start) && (cycle < rs_start + rs_len);
        end
    end

    // Output monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (resend) begin
                assert (dout == '0) else begin
                    $display("mismatch at %0t: output %h while resend is high", $time, dout);
                    error_count++;
                end
            end
            if (dout[VALID_POS]) begin
                mon_src = int'(dout[ADDR_LSB +: ADDR_BITS]);
                assert (mon_src >= 1 && mon_src <= NUM_OUT_PORTS) else begin
                    $display("mismatch at %0t: output packet has unknown source %0d",
                             $time, mon_src);
                    error_count++;
                end
                if (mon_src >= 1 && mon_src <= NUM_OUT_PORTS) begin
                    got_q[mon_src-1].push_back(dout);
                end
            end
        end
    end

    function automatic packet_t make_packet(input leaf_t leaf, input port_t port,
                                            input logic [ADDR_BITS-1:0] addr, input word_t data);
        packet_t p;
        p = '0;
        p[VALID_POS]             = 1'b1;
        p[LEAF_LSB +: LEAF_BITS] = leaf;
        p[PORT_LSB +: PORT_BITS] = port;
        p[ADDR_LSB +: ADDR_BITS] = addr;
        p[PAYLOAD_BITS-1:0]      = data;
        return p;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One cycle on the link, then an idle gap of 0 to 3 cycles
    task automatic drive_packet(input packet_t pkt);
        din = pkt;
        wait_cycles(1);
        din = '0;
        wait_cycles(int'($urandom % 4));
    endtask

    task automatic expect_no_packets(input string when);
        for (int s = 0; s < NUM_OUT_PORTS; s++) begin
            check_count++;
            assert (got_q[s].size() == 0) else begin
                $display("Test %s got %0d unexpected packets from source %0d %s",
                         test_name, got_q[s].size(), s + 1, when);
                error_count++;
            end
            got_q[s].delete();
        end
    endtask

    task automatic close_test();
        int      waited;
        packet_t got;
        packet_t exp;
        for (int s = 0; s < NUM_OUT_PORTS; s++) begin
            while (exp_q[s].size() > 0) begin
                exp    = exp_q[s].pop_front();
                waited = 0;
                while (got_q[s].size() == 0 && waited < TIMEOUT_CYCLES) begin
                    wait_cycles(1);
                    waited++;
                end
                check_count++;
                if (got_q[s].size() == 0) begin
                    $display("Test %s timed out after %0d cycles waiting for source %0d",
                             test_name, TIMEOUT_CYCLES, s + 1);
                    error_count++;
                end else begin
                    got = got_q[s].pop_front();
                    assert (got == exp) else begin
                        $display("mismatch at %0t: source %0d got %h, expected %h",
                                 $time, s + 1, got, exp);
                        error_count++;
                    end
                end
            end
        end
        wait_cycles(SETTLE_CYCLES);
        expect_no_packets("after the expected ones");
        $display("Test %s done: %0d checks, %0d errors", test_name,
                 check_count - test_checks, error_count - test_errors);
        test_open = 1'b0;
    endtask

    initial begin
        int          fd;
        int          code;
        logic        done;
        string       kind;
        string       line;
        logic [31:0] f1, f2, f3, f4;
        rst_n       = 1'b0;
        ap_start    = 1'b0;
        din         = '0;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        test_open   = 1'b0;
        void'($urandom(32'hb2a8_f444));
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fd = $fopen("test/leaf_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/leaf_tests.txt");
            error_count++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    code = $fgets(line, fd);
                end else if (kind == "test") begin
                    code = $fscanf(fd, "%s", line);
                    if (test_open) close_test();
                    test_count++;
                    test_name   = line;
                    test_checks = check_count;
                    test_errors = error_count;
                    test_open   = 1'b1;
                end else if (kind == "cfg") begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    drive_packet(make_packet('0, '0, ADDR_BITS'(f1),
                                 word_t'({f2[LEAF_BITS-1:0], f3[PORT_BITS-1:0]})));
                end else if (kind == "start") begin
                    ap_start = 1'b1;
                    wait_cycles(1);
                    ap_start = 1'b0;
                end else if (kind == "quiet") begin
                    code = $fscanf(fd, "%h", f1);
                    wait_cycles(int'(f1));
                    expect_no_packets("before ap_start");
                end else if (kind == "resend") begin
                    code = $fscanf(fd, "%h %h", f1, f2);
                    rs_start = cycle + int'(f1);  // Offset of at least 1
                    rs_len   = int'(f2);
                end else if (kind == "pair") begin
                    code = $fscanf(fd, "%h %h", f1, f2);
                    drive_packet(make_packet('0, port_t'(1), '0, f1));
                    drive_packet(make_packet('0, port_t'(2), '0, f2));
                end else if (kind == "expect") begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    exp_q[int'(f3[1:0]) - 1].push_back(make_packet(leaf_t'(f1),
                        port_t'(f2), ADDR_BITS'(f3), f4));
                end else begin
                    $display("Unknown record %s in the tests file", kind);
                    error_count++;
                    done = 1'b1;
                end
            end
            if (test_open) close_test();
            $fclose(fd);
        end
        if (check_count == 0) begin
            $display("No checks were run");
            error_count++;
        end
        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/leaf_i2o3.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_i2o3 (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire leaf_pkg::packet_t din_leaf_bft2interface,
    output wire leaf_pkg::packet_t dout_leaf_interface2bft,
    input  wire                    resend,
    input  wire                    ap_start
);
    import leaf_pkg::*;

    wire word_t dout_leaf_interface2user_2, dout_leaf_interface2user_1;
    wire        vld_interface2user_2, vld_interface2user_1;
    wire        ack_user2interface_2, ack_user2interface_1;

    wire word_t din_leaf_user2interface_3, din_leaf_user2interface_2, din_leaf_user2interface_1;
    wire        vld_user2interface_3, vld_user2interface_2, vld_user2interface_1;
    wire        ack_interface2user_3, ack_interface2user_2, ack_interface2user_1;

    wire        reset_ap_start_user;

    leaf_interface i_leaf_interface (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .dout_leaf_interface2user ({dout_leaf_interface2user_2, dout_leaf_interface2user_1}),
        .vld_interface2user       ({vld_interface2user_2, vld_interface2user_1}),
        .ack_user2interface       ({ack_user2interface_2, ack_user2interface_1}),
        .din_leaf_user2interface  ({din_leaf_user2interface_3, din_leaf_user2interface_2,
                                    din_leaf_user2interface_1}),
        .vld_user2interface       ({vld_user2interface_3, vld_user2interface_2,
                                    vld_user2interface_1}),
        .ack_interface2user       ({ack_interface2user_3, ack_interface2user_2,
                                    ack_interface2user_1}),
        .reset_ap_start_user      (reset_ap_start_user)
    );

    pair_kernel i_pair_kernel (
        .clk                        (clk),
        .rst_n                      (reset_ap_start_user),
        .dout_leaf_interface2user_1 (dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2 (dout_leaf_interface2user_2),
        .vld_interface2user_1       (vld_interface2user_1),
        .vld_interface2user_2       (vld_interface2user_2),
        .ack_user2interface_1       (ack_user2interface_1),
        .ack_user2interface_2       (ack_user2interface_2),
        .din_leaf_user2interface_1  (din_leaf_user2interface_1),
        .din_leaf_user2interface_2  (din_leaf_user2interface_2),
        .din_leaf_user2interface_3  (din_leaf_user2interface_3),
        .vld_user2interface_1       (vld_user2interface_1),
        .vld_user2interface_2       (vld_user2interface_2),
        .vld_user2interface_3       (vld_user2interface_3),
        .ack_interface2user_1       (ack_interface2user_1),
        .ack_interface2user_2       (ack_interface2user_2),
        .ack_interface2user_3       (ack_interface2user_3)
    );

endmodule

`default_nettype wire

/* verilog/leaf_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_interface (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                resend,
    input  wire                                                ap_start,
    input  wire leaf_pkg::packet_t                             din_leaf_bft2interface,
    output wire leaf_pkg::packet_t                             dout_leaf_interface2bft,
    output wire leaf_pkg::word_t [leaf_pkg::NUM_IN_PORTS-1:0]  dout_leaf_interface2user,
    output wire [leaf_pkg::NUM_IN_PORTS-1:0]                   vld_interface2user,
    input  wire [leaf_pkg::NUM_IN_PORTS-1:0]                   ack_user2interface,
    input  wire leaf_pkg::word_t [leaf_pkg::NUM_OUT_PORTS-1:0] din_leaf_user2interface,
    input  wire [leaf_pkg::NUM_OUT_PORTS-1:0]                  vld_user2interface,
    output wire [leaf_pkg::NUM_OUT_PORTS-1:0]                  ack_interface2user,
    output wire                                                reset_ap_start_user
);
    import leaf_pkg::*;

    wire route_t [NUM_OUT_PORTS-1:0] routes;
    wire [NUM_IN_PORTS-1:0]          fifo_wr_en;
    wire word_t                      fifo_wr_data;
    logic                            started;

    leaf_unpacker i_unpacker (
        .clk     (clk),
        .rst_n   (rst_n),
        .din     (din_leaf_bft2interface),
        .routes  (routes),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in_fifo
        stream_fifo i_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (fifo_wr_en[i]),
            .wr_data (fifo_wr_data),
            .rd_data (dout_leaf_interface2user[i]),
            .rd_vld  (vld_interface2user[i]),
            .rd_ack  (ack_user2interface[i])
        );
    end

    leaf_packer i_packer (
        .clk    (clk),
        .rst_n  (rst_n),
        .resend (resend),
        .routes (routes),
        .din    (din_leaf_user2interface),
        .vld    (vld_user2interface),
        .ack    (ack_interface2user),
        .dout   (dout_leaf_interface2bft)
    );

    // Kernel stays in reset until the first ap_start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    assign reset_ap_start_user = started;  // Active low

endmodule

`default_nettype wire

/* verilog/leaf_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_packer (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                resend,
    input  wire leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0] routes,
    input  wire leaf_pkg::word_t  [leaf_pkg::NUM_OUT_PORTS-1:0] din,
    input  wire [leaf_pkg::NUM_OUT_PORTS-1:0]                  vld,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                 ack,
    output leaf_pkg::packet_t                                  dout
);
    import leaf_pkg::*;

    logic [OUT_SEL_BITS-1:0] last;  // Port served last
    logic [OUT_SEL_BITS-1:0] sel;
    logic                    grant;
    leaf_t                   dst_leaf;
    port_t                   dst_port;
    packet_t                 pkt;
    packet_t                 pkt_q;

    // Round-robin search starting after the last winner
    always_comb begin
        int idx;
        grant = 1'b0;
        sel   = last;
        idx   = 0;
        if (!resend) begin
            for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
                idx = (int'(last) + k) % NUM_OUT_PORTS;
                if (!grant && vld[idx]) begin
                    grant = 1'b1;
                    sel   = OUT_SEL_BITS'(idx);
                end
            end
        end
    end

    assign ack = grant ? (NUM_OUT_PORTS'(1) << sel) : '0;

    assign dst_leaf = routes[sel][PORT_BITS +: LEAF_BITS];
    assign dst_port = routes[sel][PORT_BITS-1:0];

    always_comb begin
        pkt = '0;
        pkt[VALID_POS]                = 1'b1;
        pkt[LEAF_LSB +: LEAF_BITS]    = dst_leaf;
        pkt[PORT_LSB +: PORT_BITS]    = dst_port;
        pkt[ADDR_LSB +: ADDR_BITS]    = ADDR_BITS'(sel) + 1'b1;  // Source output 1 to 3
        pkt[PAYLOAD_BITS-1:0]         = din[sel];
    end

    // A packet caught by resend stays in the register until the link is free again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_q <= '0;
            last  <= OUT_SEL_BITS'(NUM_OUT_PORTS - 1);
        end else if (!resend) begin
            pkt_q <= grant ? pkt : '0;
            if (grant) begin
                last <= sel;
            end
        end
    end

    assign dout = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

/* verilog/leaf_pkg.sv */
`default_nettype none

package leaf_pkg;

    // Network packet and user word widths
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    // Field positions within a packet
    localparam int VALID_POS = 48;
    localparam int LEAF_LSB  = 43;
    localparam int PORT_LSB  = 39;
    localparam int ADDR_LSB  = 32;

    // User side of this leaf
    localparam int NUM_IN_PORTS  = 2;
    localparam int NUM_OUT_PORTS = 3;
    localparam int OUT_SEL_BITS  = $clog2(NUM_OUT_PORTS);

    typedef logic [PACKET_BITS-1:0]  packet_t;
    typedef logic [PAYLOAD_BITS-1:0] word_t;
    typedef logic [LEAF_BITS-1:0]    leaf_t;
    typedef logic [PORT_BITS-1:0]    port_t;

    // Table entry with the leaf in the upper bits
    typedef logic [LEAF_BITS+PORT_BITS-1:0] route_t;

endpackage

`default_nettype wire

/* verilog/leaf_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_unpacker (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire leaf_pkg::packet_t                          din,
    output leaf_pkg::route_t [leaf_pkg::NUM_OUT_PORTS-1:0]  routes,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]               wr_en,
    output leaf_pkg::word_t                                 wr_data
);
    import leaf_pkg::*;

    logic                 pkt_vld;
    port_t                dst_port;
    logic [ADDR_BITS-1:0] addr;

    // Every valid packet is taken whatever its leaf field
    assign pkt_vld  = din[VALID_POS];
    assign dst_port = din[PORT_LSB +: PORT_BITS];
    assign addr     = din[ADDR_LSB +: ADDR_BITS];
    assign wr_data  = din[PAYLOAD_BITS-1:0];

    // Port 1 feeds queue 0 and port 2 feeds queue 1
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            wr_en[i] = pkt_vld && (dst_port == PORT_BITS'(i + 1));
        end
    end

    // Port 0 carries configuration and its address picks the output port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            routes <= '0;
        end else if (pkt_vld && (dst_port == '0)) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (addr == ADDR_BITS'(i + 1)) begin
                    routes[i] <= din[$bits(route_t)-1:0];  // Low payload bits
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pair_kernel.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_kernel (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire leaf_pkg::word_t dout_leaf_interface2user_1,
    input  wire leaf_pkg::word_t dout_leaf_interface2user_2,
    input  wire                  vld_interface2user_1,
    input  wire                  vld_interface2user_2,
    output wire                  ack_user2interface_1,
    output wire                  ack_user2interface_2,
    output leaf_pkg::word_t      din_leaf_user2interface_1,
    output leaf_pkg::word_t      din_leaf_user2interface_2,
    output leaf_pkg::word_t      din_leaf_user2interface_3,
    output wire                  vld_user2interface_1,
    output wire                  vld_user2interface_2,
    output wire                  vld_user2interface_3,
    input  wire                  ack_interface2user_1,
    input  wire                  ack_interface2user_2,
    input  wire                  ack_interface2user_3
);
    import leaf_pkg::*;

    word_t                    result [NUM_OUT_PORTS];
    word_t                    res_q  [NUM_OUT_PORTS];
    logic [NUM_OUT_PORTS-1:0] res_vld;
    logic [NUM_OUT_PORTS-1:0] res_ack;
    logic                     accept;

    // Join both inputs with one pair in flight
    assign accept = vld_interface2user_1 && vld_interface2user_2 && (res_vld == '0);
    assign ack_user2interface_1 = accept;
    assign ack_user2interface_2 = accept;

    assign result[0] = dout_leaf_interface2user_1 + dout_leaf_interface2user_2;
    assign result[1] = dout_leaf_interface2user_1 ^ dout_leaf_interface2user_2;
    assign result[2] = dout_leaf_interface2user_1 - dout_leaf_interface2user_2;

    assign res_ack = {ack_interface2user_3, ack_interface2user_2, ack_interface2user_1};

    always_ff @(posedge clk) begin
        if (accept) begin
            res_q <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld <= '0;
        end else begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (accept) begin
                    res_vld[i] <= 1'b1;
                end else if (res_ack[i]) begin
                    res_vld[i] <= 1'b0;  // Each result leaves on its own
                end
            end
        end
    end

    assign din_leaf_user2interface_1 = res_q[0];
    assign din_leaf_user2interface_2 = res_q[1];
    assign din_leaf_user2interface_3 = res_q[2];
    assign vld_user2interface_1      = res_vld[0];
    assign vld_user2interface_2      = res_vld[1];
    assign vld_user2interface_3      = res_vld[2];

endmodule

`default_nettype wire

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int DEPTH = 4
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             wr_en,
    input  wire leaf_pkg::word_t wr_data,
    output leaf_pkg::word_t rd_data,
    output logic            rd_vld,
    input  wire             rd_ack
);
    import leaf_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    word_t               mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_wr;
    logic                do_rd;

    assign do_wr = wr_en && (count != CNT_BITS'(DEPTH));  // Full queue drops the word
    assign do_rd = rd_vld && rd_ack;

    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
